// ==== design/main_pkg.sv ====
// Main CPU board package with bus types, region and control enums, and fixed constants
`default_nettype none

package main_pkg;

    typedef logic [19:1] bus_addr_t;   // 68000 word address
    typedef logic [15:0] bus_data_t;
    typedef logic [7:0]  byte_t;

    // Index into the active-region vector from the mapper
    typedef enum logic [2:0] {
        region_mem = 3'd0,
        region_scr = 3'd1,
        region_pal = 3'd2,
        region_obj = 3'd3,
        region_io  = 3'd4,
        region_sub = 3'd5
    } region_e;

    typedef enum logic [1:0] {
        game_outrun  = 2'd0,   // Big cabinet
        game_shangon = 2'd1    // Motorbike
    } game_e;

    // Other codes give zero pedals
    typedef enum logic [2:0] {
        ctrl_dual_stick = 3'd0,
        ctrl_trigger    = 3'd1,
        ctrl_wheel      = 3'd2
    } ctrl_e;

    typedef enum logic [2:0] {
        adc_wheel = 3'd0,
        adc_gas   = 3'd1,
        adc_brake = 3'd2,
        adc_motor = 3'd3
    } adc_ch_e;

    localparam int        REGION_N = 6;
    localparam bus_data_t OPEN_BUS = 16'hffff;

    // Digital overrides for the analog channels
    localparam byte_t OR_LEFT     = 8'he0;
    localparam byte_t OR_RIGHT    = 8'h20;
    localparam byte_t SH_LEFT     = 8'h20;
    localparam byte_t SH_RIGHT    = 8'hd0;
    localparam byte_t PEDAL_FULL  = 8'hff;

endpackage

`default_nettype wire

// ==== design/bus_cs_decode.sv ====
// Bus chip-select decoder, registers region selects from the mapper and CPU strobes
`timescale 1ns/1ps
`default_nettype none

module bus_cs_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [main_pkg::REGION_N-1:0] region_active,
    input  main_pkg::bus_addr_t           addr,
    input  logic                          as_n,
    input  logic                          uds_n,
    input  logic                          lds_n,
    input  logic                          rnw,
    output logic                          rom_cs,
    output logic                          ram_cs,
    output logic                          vram_cs,
    output logic                          char_cs,
    output logic                          pal_cs,
    output logic                          objram_cs,
    output logic                          io_cs,
    output logic                          sub_cs
);
    import main_pkg::*;

    logic ds_active;   // At least one data strobe low
    logic qualified;
    logic ram_area;    // Top of the mem region, $60000 up

    assign ds_active = !(uds_n && lds_n);
    assign qualified = ds_active || (!as_n && rnw);
    assign ram_area  = addr[18:17] == 2'b11;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
        end else begin
            rom_cs    <= qualified && region_active[region_mem] && !ram_area;
            ram_cs    <= qualified && region_active[region_mem] && ram_area && ds_active;
            char_cs   <= qualified && region_active[region_scr] && addr[16];
            vram_cs   <= qualified && region_active[region_scr] && !addr[16] && ds_active;
            pal_cs    <= qualified && region_active[region_pal];
            objram_cs <= qualified && region_active[region_obj];
            io_cs     <= qualified && region_active[region_io];
            sub_cs    <= qualified && region_active[region_sub];
        end
    end

endmodule

`default_nettype wire

// ==== design/ppi_port.sv ====
// Simplified 8255 parallel port in mode 0, three output ports with readback
`timescale 1ns/1ps
`default_nettype none

module ppi_port (
    input  logic            clk,
    input  logic            rst,
    input  logic            ppi_cs,
    input  logic [1:0]      addr,
    input  main_pkg::byte_t din,
    input  logic            rnw,
    input  logic            lds_n,
    output main_pkg::byte_t dout,
    output main_pkg::byte_t port_b,
    output main_pkg::byte_t port_c
);
    import main_pkg::*;

    byte_t port_a;
    byte_t ctrl_word;
    byte_t port_a_rd;
    logic  wr_en;

    assign wr_en = ppi_cs && !rnw && !lds_n;

    // Port A set as input reads the unconnected pins, motor limits included
    assign port_a_rd = ctrl_word[4] ? 8'hff : port_a;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_a    <= '0;
            port_b    <= '0;
            port_c    <= '0;
            ctrl_word <= '0;
        end else if (wr_en) begin
            case (addr)
                2'd0: port_a <= din;
                2'd1: port_b <= din;
                2'd2: port_c <= din;
                2'd3: begin
                    if (din[7]) begin
                        ctrl_word <= din;   // Mode set
                    end else begin
                        port_c[din[3:1]] <= din[0];   // Bit set/reset
                    end
                end
                default: ;
            endcase
        end
    end

    // Readback is combinational
    always_comb begin
        case (addr)
            2'd0:    dout = port_a_rd;
            2'd1:    dout = port_b;
            2'd2:    dout = port_c;
            default: dout = ctrl_word;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/sys_ctrl_latch.sv ====
// System control latch for sprite config, video enable, ADC channel and sound reset
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl_latch (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::game_e     game,
    input  main_pkg::byte_t     port_c,
    input  logic                io_cs,
    input  main_pkg::bus_addr_t addr,
    input  main_pkg::bus_data_t cpu_dout,
    input  logic                rnw,
    input  logic                lds_n,
    output logic [1:0]          obj_cfg,
    output logic                video_en,
    output logic                snd_rstb,
    output main_pkg::adc_ch_e   adc_ch
);
    import main_pkg::*;

    logic       low_wr;
    logic [2:0] wr_code;

    assign low_wr  = io_cs && !rnw && !lds_n;
    assign wr_code = {addr[13:12], addr[5]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            obj_cfg  <= 2'b00;
            video_en <= 1'b1;
            snd_rstb <= 1'b1;
            adc_ch   <= adc_wheel;
        end else if (game == game_outrun) begin
            obj_cfg  <= port_c[7:6];   // [1] sprite engine, [0] colour mixer
            video_en <= port_c[5];
            adc_ch   <= adc_ch_e'(port_c[4:2]);
            snd_rstb <= port_c[0];
        end else if (game == game_shangon && low_wr) begin
            if (wr_code == 3'd0) begin
                adc_ch   <= adc_ch_e'({1'b0, cpu_dout[7:6]});
                video_en <= cpu_dout[4];
            end else if (wr_code == 3'd1) begin
                snd_rstb <= ~cpu_dout[0];   // Written as reset, held as run
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cab_io.sv ====
// Cabinet input read multiplexer with analog latch and per-controller ADC conversion
`timescale 1ns/1ps
`default_nettype none

module cab_io (
    input  logic                clk,
    input  logic                rst,
    input  main_pkg::game_e     game,
    input  main_pkg::ctrl_e     ctrl_type,
    input  logic                io_cs,
    input  main_pkg::bus_addr_t addr,
    input  logic                rnw,
    input  main_pkg::adc_ch_e   adc_ch,
    input  main_pkg::byte_t     ppi_dout,
    input  main_pkg::byte_t     joystick1,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    input  main_pkg::byte_t     dipsw_a,
    input  main_pkg::byte_t     dipsw_b,
    input  main_pkg::bus_data_t joyana1,
    input  main_pkg::bus_data_t joyana1b,
    output main_pkg::byte_t     cab_dout,
    output logic                ppi_cs,
    output logic                obj_toggle
);
    import main_pkg::*;

    bus_data_t ana_a;    // Wheel word
    bus_data_t ana_b;    // Pedal word
    logic      adc_wr;
    logic [2:0] sh_code;
    byte_t     hi_mag, lo_mag;
    byte_t     wheel_val, gas_val, brake_val, adc_val;
    logic      gas_btn, brake_btn;

    assign sh_code = {addr[13:12], addr[5]};

    // Magnitudes with the sign bit stripped and the LSB padded
    assign hi_mag = {ana_b[14:8], ana_b[14]};
    assign lo_mag = {ana_b[6:0], ana_b[6]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ana_a <= '0;
            ana_b <= '0;
        end else if (adc_wr) begin
            ana_a <= joyana1;
            ana_b <= joyana1b;
        end
    end

    // Override buttons sit on different bits per cabinet
    assign gas_btn   = (game == game_outrun) ? joystick1[4] : joystick1[3];
    assign brake_btn = (game == game_outrun) ? joystick1[5] : joystick1[2];

    always_comb begin
        wheel_val = ana_a[7:0] ^ 8'h80;
        if (game == game_outrun) begin
            if (!joystick1[0]) wheel_val = OR_LEFT;
            if (!joystick1[1]) wheel_val = OR_RIGHT;   // Right wins
        end else begin
            if (!joystick1[1]) wheel_val = SH_RIGHT;
            if (!joystick1[0]) wheel_val = SH_LEFT;    // Left wins
        end

        case (ctrl_type)
            ctrl_dual_stick, ctrl_wheel: gas_val = ana_b[15] ? ~hi_mag : 8'h00;
            ctrl_trigger:                gas_val = ana_b[7] ? 8'h00 : lo_mag;
            default:                     gas_val = 8'h00;
        endcase
        if (!gas_btn) gas_val = PEDAL_FULL;

        case (ctrl_type)
            ctrl_dual_stick, ctrl_trigger: brake_val = ana_b[15] ? 8'h00 : hi_mag;
            ctrl_wheel:                    brake_val = ana_b[15] ? ~hi_mag : 8'h00;
            default:                       brake_val = 8'h00;
        endcase
        if (!brake_btn) brake_val = PEDAL_FULL;

        case (adc_ch)
            adc_wheel: adc_val = wheel_val;
            adc_gas:   adc_val = gas_val;
            adc_brake: adc_val = brake_val;
            default:   adc_val = 8'hff;   // No motor fitted
        endcase
    end

    always_comb begin
        ppi_cs     = 1'b0;
        cab_dout   = 8'hff;
        obj_toggle = 1'b0;
        adc_wr     = 1'b0;
        if (io_cs && game == game_outrun) begin
            case (addr[6:4])
                3'd0: begin
                    ppi_cs   = 1'b1;
                    cab_dout = ppi_dout;
                end
                3'd1: begin
                    case (addr[2:1])
                        2'd0: cab_dout = {coin_input, ~joystick1[7], joystick1[6],
                                          start_button[0], service, dip_test, 1'b1};
                        2'd2: cab_dout = dipsw_a;
                        2'd3: cab_dout = dipsw_b;
                        default: ;
                    endcase
                end
                3'd3: begin
                    cab_dout = adc_val;
                    adc_wr   = !rnw;
                end
                3'd7: obj_toggle = 1'b1;
                default: ;
            endcase
        end else if (io_cs && game == game_shangon) begin
            case (sh_code)
                3'd2: begin
                    case (addr[2:1])
                        2'd1: cab_dout = {2'b11, joystick1[4], start_button[1],
                                          service, dip_test, coin_input};
                        2'd2: cab_dout = dipsw_a;
                        2'd3: cab_dout = dipsw_b;
                        default: ;
                    endcase
                end
                3'd7: begin
                    cab_dout = adc_val;
                    adc_wr   = !rnw;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu_read_mux.sv ====
// CPU read-data multiplexer, registers the selected source onto the data bus
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux (
    input  logic                clk,
    input  logic                rst,
    input  logic                rom_cs,
    input  logic                ram_cs,
    input  logic                vram_cs,
    input  logic                char_cs,
    input  logic                pal_cs,
    input  logic                objram_cs,
    input  logic                io_cs,
    input  logic                sub_cs,
    input  main_pkg::bus_data_t ram_data,   // Work RAM or VRAM
    input  main_pkg::bus_data_t rom_data,
    input  main_pkg::bus_data_t char_dout,
    input  main_pkg::bus_data_t pal_dout,
    input  main_pkg::bus_data_t obj_dout,
    input  main_pkg::bus_data_t sub_din,
    input  main_pkg::byte_t     cab_dout,
    output main_pkg::bus_data_t cpu_din
);
    import main_pkg::*;

    bus_data_t rd_next;

    always_comb begin
        if (ram_cs || vram_cs) rd_next = ram_data;
        else if (rom_cs)       rd_next = rom_data;   // No decryption
        else if (char_cs)      rd_next = char_dout;
        else if (pal_cs)       rd_next = pal_dout;
        else if (objram_cs)    rd_next = obj_dout;
        else if (sub_cs)       rd_next = sub_din;
        else if (io_cs)        rd_next = {8'hff, cab_dout};
        else                   rd_next = OPEN_BUS;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) cpu_din <= '0;
        else     cpu_din <= rd_next;
    end

endmodule

`default_nettype wire

// ==== design/outrun_main.sv ====
// Main board I/O and bus glue top, wires decoder, PPI, control latch, cabinet I/O and read mux
`timescale 1ns/1ps
`default_nettype none

module outrun_main (
    input  logic                          clk,
    input  logic                          rst,
    input  main_pkg::game_e               game,
    input  main_pkg::ctrl_e               ctrl_type,
    // CPU bus
    input  logic [main_pkg::REGION_N-1:0] region_active,
    input  main_pkg::bus_addr_t           addr,
    input  logic                          as_n,
    input  logic                          uds_n,
    input  logic                          lds_n,
    input  logic                          rnw,
    input  main_pkg::bus_data_t           cpu_dout,
    output main_pkg::bus_data_t           cpu_din,
    // Chip selects
    output logic                          rom_cs,
    output logic                          ram_cs,
    output logic                          vram_cs,
    output logic                          char_cs,
    output logic                          pal_cs,
    output logic                          objram_cs,
    output logic                          io_cs,
    output logic                          sub_cs,
    // Memory read data
    input  main_pkg::bus_data_t           ram_data,
    input  main_pkg::bus_data_t           rom_data,
    input  main_pkg::bus_data_t           char_dout,
    input  main_pkg::bus_data_t           pal_dout,
    input  main_pkg::bus_data_t           obj_dout,
    input  main_pkg::bus_data_t           sub_din,
    // Cabinet
    input  main_pkg::byte_t               joystick1,
    input  logic [1:0]                    start_button,
    input  logic [1:0]                    coin_input,
    input  logic                          service,
    input  logic                          dip_test,
    input  main_pkg::byte_t               dipsw_a,
    input  main_pkg::byte_t               dipsw_b,
    input  main_pkg::bus_data_t           joyana1,
    input  main_pkg::bus_data_t           joyana1b,
    // Video and sound control
    output main_pkg::byte_t               port_b,
    output logic [1:0]                    obj_cfg,
    output logic                          video_en,
    output logic                          snd_rstb,
    output logic                          obj_toggle
);
    import main_pkg::*;

    logic    ppi_cs;
    byte_t   port_c;
    byte_t   ppi_dout;
    byte_t   cab_dout;
    adc_ch_e adc_ch;

    bus_cs_decode u_decode (
        .clk(clk), .rst(rst), .region_active(region_active), .addr(addr),
        .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n), .rnw(rnw),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs), .sub_cs(sub_cs)
    );

    ppi_port u_ppi (
        .clk(clk), .rst(rst), .ppi_cs(ppi_cs), .addr(addr[2:1]), .din(cpu_dout[7:0]),
        .rnw(rnw), .lds_n(lds_n), .dout(ppi_dout), .port_b(port_b), .port_c(port_c)
    );

    sys_ctrl_latch u_ctrl (
        .clk(clk), .rst(rst), .game(game), .port_c(port_c), .io_cs(io_cs),
        .addr(addr), .cpu_dout(cpu_dout), .rnw(rnw), .lds_n(lds_n),
        .obj_cfg(obj_cfg), .video_en(video_en), .snd_rstb(snd_rstb), .adc_ch(adc_ch)
    );

    cab_io u_cab (
        .clk(clk), .rst(rst), .game(game), .ctrl_type(ctrl_type), .io_cs(io_cs),
        .addr(addr), .rnw(rnw), .adc_ch(adc_ch), .ppi_dout(ppi_dout),
        .joystick1(joystick1), .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .joyana1(joyana1), .joyana1b(joyana1b),
        .cab_dout(cab_dout), .ppi_cs(ppi_cs), .obj_toggle(obj_toggle)
    );

    cpu_read_mux u_rdmux (
        .clk(clk), .rst(rst),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs), .sub_cs(sub_cs),
        .ram_data(ram_data), .rom_data(rom_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .sub_din(sub_din),
        .cab_dout(cab_dout), .cpu_din(cpu_din)
    );

endmodule

`default_nettype wire

// ==== testbench/outrun_assertions.sv ====
// Bound checks on chip-select exclusivity, sprite toggle and reset state
`timescale 1ns/1ps
`default_nettype none

module outrun_assertions (
    input logic clk,
    input logic rst,
    input logic [main_pkg::REGION_N-1:0] region_active,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs,
    input logic char_cs,
    input logic pal_cs,
    input logic objram_cs,
    input logic io_cs,
    input logic sub_cs,
    input logic obj_toggle
);
    import main_pkg::*;

    logic [7:0] sel;

    assign sel = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, sub_cs};

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else $error("more than one chip select active");

    // Toggle only after an io access seen by the decoder on the edge before
    a_toggle_io: assert property (@(posedge clk) disable iff (rst)
        obj_toggle |-> $past(region_active[region_io]))
        else $error("sprite toggle without a preceding io access");

    a_reset_sel: assert property (@(posedge clk) $past(rst) |-> sel == 8'h00)
        else $error("chip select active during reset");

endmodule

bind outrun_main outrun_assertions u_assert (
    .clk(clk), .rst(rst), .region_active(region_active),
    .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs),
    .char_cs(char_cs), .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs),
    .sub_cs(sub_cs), .obj_toggle(obj_toggle)
);

`default_nettype wire

// ==== testbench/tb_outrun_main.sv ====
// Pattern-driven testbench for the main board I/O and bus glue
`timescale 1ns/1ps
`default_nettype none

module tb_outrun_main;
    import main_pkg::*;

    localparam int MAX_PAT = 64;

    logic clk, rst;
    game_e game;
    ctrl_e ctrl_type;
    logic [REGION_N-1:0] region_active;
    bus_addr_t addr;
    logic as_n, uds_n, lds_n, rnw;
    bus_data_t cpu_dout, cpu_din;
    logic rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, sub_cs;
    bus_data_t ram_data, rom_data, char_dout, pal_dout, obj_dout, sub_din;
    byte_t joystick1, dipsw_a, dipsw_b, port_b;
    logic [1:0] start_button, coin_input, obj_cfg;
    logic service, dip_test, video_en, snd_rstb, obj_toggle;
    bus_data_t joyana1, joyana1b;

    // One row per operation
    logic [31:0] p_op [MAX_PAT], p_game [MAX_PAT], p_ctrl [MAX_PAT], p_mask [MAX_PAT];
    logic [31:0] p_addr [MAX_PAT], p_data [MAX_PAT], p_joy [MAX_PAT];
    logic [31:0] p_ana [MAX_PAT], p_anb [MAX_PAT], p_kind [MAX_PAT], p_exp [MAX_PAT];
    int n_pat = 0;
    int cycle_limit = 1000000;
    int cycles = 0;
    byte_t port_b_exp = '0;   // Last value written to PPI port B

    outrun_main dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("*** FAILED ***");
            $fatal(1, "run did not finish");
        end
    end

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "data compare");
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "byte compare");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "flag compare");
        end
    endtask

    // Selects for one region with a data strobe low, {rom, ram, vram, char, pal, obj, io, sub}
    function automatic byte_t expected_selects(input logic [31:0] mask,
                                               input logic [31:0] byte_addr);
        byte_t sel;
        sel[7] = mask[region_mem] && byte_addr[18:17] != 2'b11;
        sel[6] = mask[region_mem] && byte_addr[18:17] == 2'b11;   // Work RAM at $60000
        sel[5] = mask[region_scr] && !byte_addr[16];
        sel[4] = mask[region_scr] && byte_addr[16];
        sel[3] = mask[region_pal];
        sel[2] = mask[region_obj];
        sel[1] = mask[region_io];
        sel[0] = mask[region_sub];
        return sel;
    endfunction

    task automatic load_patterns();
        int fd;
        int n;
        string line;
        fd = $fopen("testbench/bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            $display("*** FAILED ***");
            $fatal(1, "no patterns");
        end
        while (!$feof(fd) && n_pat < MAX_PAT) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 4 || line.getc(0) == "#") continue;   // Header and blanks
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", p_op[n_pat], p_game[n_pat],
                        p_ctrl[n_pat], p_mask[n_pat], p_addr[n_pat], p_data[n_pat],
                        p_joy[n_pat], p_ana[n_pat], p_anb[n_pat], p_kind[n_pat], p_exp[n_pat]);
            if (n == 11) n_pat++;
        end
        $fclose(fd);
    endtask

    task automatic bus_idle();
        as_n  = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw   = 1'b1;
        region_active = '0;
    endtask

    task automatic drive_bus(input int i);
        region_active = p_mask[i][REGION_N-1:0];
        addr     = p_addr[i][19:1];   // File holds byte addresses
        cpu_dout = p_data[i][15:0];
        as_n     = 1'b0;
        rnw      = (p_op[i] != 1);
        uds_n    = (p_op[i] == 1);   // Writes are low byte only
        lds_n    = 1'b0;
    endtask

    task automatic run_op(input int i);
        byte_t exp_sel;
        logic  exp_toggle;
        game      = game_e'(p_game[i][1:0]);
        ctrl_type = ctrl_e'(p_ctrl[i][2:0]);
        joystick1 = p_joy[i][7:0];
        joyana1   = p_ana[i][15:0];
        joyana1b  = p_anb[i][15:0];
        drive_bus(i);
        if (p_op[i] == 2) begin   // Reset pulse while every region is requested
            region_active = '1;
            rst = 1'b1;
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            region_active = p_mask[i][REGION_N-1:0];
            repeat (2) @(posedge clk);
            port_b_exp = '0;
        end else begin
            repeat (4) @(posedge clk);
            if (p_op[i] == 1 && game == game_outrun && p_mask[i][region_io]
                    && p_addr[i][6:4] == 3'd0 && p_addr[i][2:1] == 2'd1) begin
                port_b_exp = p_data[i][7:0];   // PPI port B
            end
        end
        #1;
        exp_sel    = expected_selects(p_mask[i], p_addr[i]);
        exp_toggle = (game == game_outrun) && p_mask[i][region_io] && (p_addr[i][6:4] == 3'd7);
        if (p_kind[i] == 0) begin
            check_data("cpu_din", cpu_din, p_exp[i][15:0]);
        end else begin
            check_byte("obj_cfg", {6'b0, obj_cfg}, {6'b0, p_exp[i][3:2]});
            check_flag("video_en", video_en, p_exp[i][1]);
            check_flag("snd_rstb", snd_rstb, p_exp[i][0]);
        end
        check_flag("rom_cs", rom_cs, exp_sel[7]);
        check_flag("ram_cs", ram_cs, exp_sel[6]);
        check_flag("vram_cs", vram_cs, exp_sel[5]);
        check_flag("char_cs", char_cs, exp_sel[4]);
        check_flag("pal_cs", pal_cs, exp_sel[3]);
        check_flag("objram_cs", objram_cs, exp_sel[2]);
        check_flag("io_cs", io_cs, exp_sel[1]);
        check_flag("sub_cs", sub_cs, exp_sel[0]);
        check_flag("obj_toggle", obj_toggle, exp_toggle);
        check_byte("port_b", port_b, port_b_exp);
    endtask

    initial begin
        rst = 1'b1;
        game = game_outrun;
        ctrl_type = ctrl_wheel;
        addr = '0;
        cpu_dout = '0;
        bus_idle();
        ram_data  = 16'h1234;
        rom_data  = 16'h2345;
        char_dout = 16'h3456;
        pal_dout  = 16'h4567;
        obj_dout  = 16'h5678;
        sub_din   = 16'h6789;
        joystick1 = 8'hff;   // Buttons are active low
        start_button = 2'b10;
        coin_input   = 2'b01;
        service  = 1'b1;
        dip_test = 1'b0;
        dipsw_a  = 8'ha5;
        dipsw_b  = 8'h5a;
        joyana1  = '0;
        joyana1b = '0;
        load_patterns();
        if (n_pat == 0) begin
            $display("pattern file holds no operations");
            $display("*** FAILED ***");
            $fatal(1, "empty patterns");
        end
        cycle_limit = 4 * n_pat + 20;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < n_pat; i++) run_op(i);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/bus_patterns.txt ====
# op(0 rd 1 wr 2 rst) game ctrl region_mask byte_addr data joystick joyana1 joyana1b
# kind(0 cpu_din, 1 ctl = obj_cfg,video_en,snd_rstb) expected
0 0 2 01 000000 0000 ff 0040 9034 0 2345
0 0 2 01 060000 0000 ff 0040 9034 0 1234
0 0 2 02 010000 0000 ff 0040 9034 0 3456
0 0 2 02 000000 0000 ff 0040 9034 0 1234
0 0 2 04 000000 0000 ff 0040 9034 0 4567
0 0 2 08 000000 0000 ff 0040 9034 0 5678
0 0 2 20 000000 0000 ff 0040 9034 0 6789
0 0 2 00 000000 0000 ff 0040 9034 0 ffff
0 0 2 10 000010 0000 ff 0040 9034 0 ff55
0 0 2 10 000014 0000 ff 0040 9034 0 ffa5
0 0 2 10 000016 0000 ff 0040 9034 0 ff5a
1 0 2 10 000030 0000 ff 0040 9034 1 0
0 0 2 10 000030 0000 ff 0040 9034 0 ffc0
0 0 2 10 000030 0000 fe 0040 9034 0 ffe0
1 0 2 10 000004 0024 ff 0040 9034 1 2
0 0 2 10 000030 0000 ff 0040 9034 0 ffdf
0 0 1 10 000030 0000 ff 0040 9034 0 ff68
0 0 2 10 000030 0000 ef 0040 9034 0 ffff
1 0 2 10 000004 0028 ff 0040 9034 1 2
0 0 2 10 000030 0000 ff 0040 9034 0 ffdf
0 0 0 10 000030 0000 ff 0040 9034 0 ff00
0 0 2 10 000004 0000 ff 0040 9034 0 ff28
1 0 2 10 000004 00e1 ff 0040 9034 1 f
0 0 2 10 000004 0000 ff 0040 9034 0 ffe1
1 0 2 10 000006 0000 ff 0040 9034 1 e
2 1 2 00 000000 0000 ff 0012 4500 1 3
1 1 2 10 000000 0040 ff 0012 4500 1 1
1 1 2 10 000020 0001 ff 0012 4500 1 0
1 1 2 10 003020 0000 ff 0012 4500 1 0
0 1 2 10 003020 0000 ff 0012 4500 0 ff00
1 1 2 10 000000 0090 ff 0012 4500 1 2
0 1 0 10 003020 0000 ff 0012 4500 0 ff8b
0 1 2 10 003020 0000 ff 0012 4500 0 ff00
0 1 0 10 003020 0000 fb 0012 4500 0 ffff
1 1 2 10 000000 0010 ff 0012 4500 1 2
0 1 2 10 003020 0000 ff 0012 4500 0 ff92
0 1 2 10 003020 0000 fe 0012 4500 0 ff20
0 1 2 10 001002 0000 ff 0012 4500 0 fff9
0 1 2 10 001004 0000 ff 0012 4500 0 ffa5
1 1 2 10 000020 0000 ff 0012 4500 1 3

// ==== sim.f ====
design/main_pkg.sv
design/bus_cs_decode.sv
design/ppi_port.sv
design/sys_ctrl_latch.sv
design/cab_io.sv
design/cpu_read_mux.sv
design/outrun_main.sv
testbench/outrun_assertions.sv
testbench/tb_outrun_main.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
verilator --binary --assert -f sim.f --top-module tb_outrun_main -o sim_tb \
    && ./obj_dir/sim_tb | grep -F "*** PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
